// File: logic/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int OFFSET_W = 4;    // byte offset bits in a line
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 24;
    localparam int WORDS    = 4;    // words per line
    localparam int NUM_SETS = 16;
    localparam int NUM_WAYS = 2;

    // encoded like the cpu size field with 0 byte, 1 half and 2 word
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } acc_size_e;

    typedef enum logic [1:0] {
        ST_LOOKUP    = 2'd0,
        ST_WRITEBACK = 2'd1,
        ST_REFILL    = 2'd2
    } ctrl_state_e;

    // wdata sits in the byte lanes picked by addr[1:0]
    typedef struct packed {
        logic        wr;
        acc_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        last;   // fourth word of a write-back
    } mem_req_t;

endpackage

// File: logic/dcache_tag_ram.sv
`timescale 1ns/10ps

module dcache_tag_ram import dcache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] index,
    input  logic               we,
    input  logic [TAG_W-1:0]   wtag,
    input  logic               wvalid,
    input  logic               wdirty,
    output logic [TAG_W-1:0]   tag,
    output logic               valid,
    output logic               dirty
);

    logic [TAG_W-1:0]    tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_mem;
    logic [NUM_SETS-1:0] dirty_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '0;
        end else if (we) begin
            valid_mem[index] <= wvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[index]   <= wtag;
            dirty_mem[index] <= wdirty;
        end
    end

    assign tag   = tag_mem[index];
    assign valid = valid_mem[index];
    assign dirty = dirty_mem[index];   // meaningless unless valid

endmodule

// File: logic/dcache_data_ram.sv
`timescale 1ns/10ps

module dcache_data_ram import dcache_pkg::*; (
    input  logic               clk,
    input  logic [INDEX_W-1:0] index,
    input  logic [1:0]         word,
    input  logic [1:0]         byte_sel,
    input  acc_size_e          size,
    input  logic               we,      // cpu store
    input  logic               fill,    // refill word from memory
    input  logic [31:0]        wdata,
    output logic [WORDS*32-1:0] line
);

    logic [WORDS*32-1:0] line_mem [NUM_SETS];
    logic [3:0]          strb;
    logic [31:0]         cur_word;
    logic [31:0]         new_word;

    assign line     = line_mem[index];
    assign cur_word = line[word*32 +: 32];

    always_comb begin
        case (size)
            SZ_BYTE: strb = 4'b0001 << byte_sel;
            SZ_HALF: strb = byte_sel[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;
        endcase
        if (fill) begin
            strb = 4'b1111;   // refill replaces the whole word
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            new_word[b*8 +: 8] = strb[b] ? wdata[b*8 +: 8] : cur_word[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (we || fill) begin
            line_mem[index][word*32 +: 32] <= new_word;
        end
    end

endmodule

// File: logic/dcache_lru.sv
`timescale 1ns/10ps

module dcache_lru import dcache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] index,
    input  logic               hit,
    input  logic               hit_way,
    output logic               victim_way
);

    // one bit per set naming the least recently used way
    logic [NUM_SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (hit) begin
            lru_bits[index] <= ~hit_way;   // the other way is now older
        end
    end

    assign victim_way = lru_bits[index];

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req,
    input  logic        hit,
    input  logic        victim_dirty,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    output ctrl_state_e state,
    output logic [1:0]  word_cnt,
    output logic        mem_req,
    output logic        mem_wen,
    output logic        wlast,
    output logic        refill_we,
    output logic        tag_we
);

    logic last_beat;

    assign last_beat = mem_data_ok && (word_cnt == 2'(WORDS - 1));

    assign mem_wen   = (state == ST_WRITEBACK);
    assign wlast     = mem_wen && (word_cnt == 2'(WORDS - 1));
    assign refill_we = (state == ST_REFILL) && mem_data_ok;   // one word per read response

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_LOOKUP;
            word_cnt <= '0;
            mem_req  <= 1'b0;
            tag_we   <= 1'b0;
        end else begin
            tag_we <= 1'b0;

            // request drops once the memory has taken it
            if (mem_req && mem_addr_ok) begin
                mem_req <= 1'b0;
            end

            if (mem_data_ok) begin
                word_cnt <= word_cnt + 2'd1;   // wraps to 0 after the fourth word
            end

            case (state)
                ST_LOOKUP: begin
                    if (cpu_req && !hit) begin
                        state   <= victim_dirty ? ST_WRITEBACK : ST_REFILL;
                        mem_req <= 1'b1;
                    end
                end

                ST_WRITEBACK: begin
                    if (mem_data_ok) begin
                        mem_req <= 1'b1;   // next write, or first refill read
                        if (last_beat) begin
                            state <= ST_REFILL;
                        end
                    end
                end

                ST_REFILL: begin
                    if (tag_we) begin
                        state <= ST_LOOKUP;   // held request hits next cycle
                    end else if (mem_data_ok) begin
                        if (last_beat) begin
                            tag_we <= 1'b1;
                        end else begin
                            mem_req <= 1'b1;
                        end
                    end
                end

                default: state <= ST_LOOKUP;
            endcase
        end
    end

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req,
    input  cpu_req_t    cpu_in,
    input  logic [31:0] mem_rdata,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    output logic        cpu_addr_ok,
    output logic        cpu_data_ok,
    output logic [31:0] data_rdata,
    output logic        mem_req,
    output mem_req_t    mem_out
);

    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    index;
    logic [OFFSET_W-3:0]   word_off;
    logic [1:0]            byte_sel;

    logic [TAG_W-1:0]      way_tag [NUM_WAYS];
    logic [WORDS*32-1:0]   way_line [NUM_WAYS];
    logic [NUM_WAYS-1:0]   way_valid;
    logic [NUM_WAYS-1:0]   way_dirty;
    logic [NUM_WAYS-1:0]   way_hit;
    logic [NUM_WAYS-1:0]   way_store_we;
    logic [NUM_WAYS-1:0]   way_fill;
    logic [NUM_WAYS-1:0]   way_tag_we;

    logic                  hit;
    logic                  hit_way;
    logic                  access_done;
    logic                  write_hit;
    logic                  victim_way;
    logic                  victim_dirty;
    logic [1:0]            ram_word;
    logic [31:0]           ram_wdata;

    ctrl_state_e           state;
    logic [1:0]            word_cnt;
    logic                  mem_wen;
    logic                  wlast;
    logic                  refill_we;
    logic                  tag_we;

    assign req_tag  = cpu_in.addr[31 -: TAG_W];
    assign index    = cpu_in.addr[OFFSET_W +: INDEX_W];
    assign word_off = cpu_in.addr[OFFSET_W-1:2];
    assign byte_sel = cpu_in.addr[1:0];

    // hits only count while the controller is idle
    assign hit         = (state == ST_LOOKUP) && |way_hit;
    assign hit_way     = way_hit[1];
    assign access_done = cpu_req && hit;
    assign write_hit   = access_done && cpu_in.wr;

    assign cpu_addr_ok = access_done;
    assign cpu_data_ok = access_done;
    assign data_rdata  = way_line[hit_way][word_off*32 +: 32];

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

    // refill words come from memory at the burst position
    assign ram_word  = (state == ST_REFILL) ? word_cnt : word_off;
    assign ram_wdata = (state == ST_REFILL) ? mem_rdata : cpu_in.wdata;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        assign way_hit[w]      = way_valid[w] && (way_tag[w] == req_tag);
        assign way_store_we[w] = write_hit && (hit_way == 1'(w));
        assign way_fill[w]     = refill_we && (victim_way == 1'(w));
        assign way_tag_we[w]   = way_store_we[w] || (tag_we && victim_way == 1'(w));

        // store hits mark the line dirty, a refill leaves it clean
        dcache_tag_ram u_tag_ram (
            .clk    (clk),
            .rst    (rst),
            .index  (index),
            .we     (way_tag_we[w]),
            .wtag   (req_tag),
            .wvalid (1'b1),
            .wdirty (!tag_we),
            .tag    (way_tag[w]),
            .valid  (way_valid[w]),
            .dirty  (way_dirty[w])
        );

        dcache_data_ram u_data_ram (
            .clk      (clk),
            .index    (index),
            .word     (ram_word),
            .byte_sel (byte_sel),
            .size     (cpu_in.size),
            .we       (way_store_we[w]),
            .fill     (way_fill[w]),
            .wdata    (ram_wdata),
            .line     (way_line[w])
        );
    end

    dcache_lru u_lru (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .hit        (access_done),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .state        (state),
        .word_cnt     (word_cnt),
        .mem_req      (mem_req),
        .mem_wen      (mem_wen),
        .wlast        (wlast),
        .refill_we    (refill_we),
        .tag_we       (tag_we)
    );

    // write-back uses the victim tag, refill the requested tag
    assign mem_out.wen   = mem_wen;
    assign mem_out.addr  = mem_wen ? {way_tag[victim_way], index, word_cnt, 2'b00}
                                   : {req_tag, index, word_cnt, 2'b00};
    assign mem_out.wdata = way_line[victim_way][word_cnt*32 +: 32];
    assign mem_out.last  = wlast;

endmodule

// File: sim/tb_dcache_model.svh
`ifndef TB_DCACHE_MODEL_SVH
`define TB_DCACHE_MODEL_SVH

logic [7:0] ref_mem [MEM_BYTES];   // what the cpu should read back byte by byte

// initial memory contents with a different word for every address
function automatic logic [31:0] fill_word(input int unsigned waddr);
    logic [31:0] x;
    x = waddr * 32'h9e3779b1;
    return x ^ {x[15:0], x[31:16]} ^ 32'ha5c30f69;
endfunction

task automatic init_reference();
    logic [31:0] w;
    for (int a = 0; a < MEM_WORDS; a++) begin
        w = fill_word(a);
        for (int b = 0; b < 4; b++) begin
            ref_mem[10'(a * 4 + b)] = w[b*8 +: 8];
        end
    end
endtask

// stores 1, 2 or 4 bytes from addr on, each taken from its own lane
task automatic store_reference(input acc_size_e size, input logic [31:0] addr,
                               input logic [31:0] wdata);
    int nbytes;
    int unsigned lane;
    nbytes = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
    for (int i = 0; i < nbytes; i++) begin
        lane = addr[1:0] + i;
        ref_mem[10'(addr + i)] = wdata[lane*8 +: 8];
    end
endtask

function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [9:0] base;
    base = {addr[9:2], 2'b00};
    return {ref_mem[base + 10'd3], ref_mem[base + 10'd2], ref_mem[base + 10'd1],
            ref_mem[base]};
endfunction

task automatic check_val(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
    end
endtask

// present one request and hold it until the cache answers
task automatic cpu_access(input logic wr, input acc_size_e size, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int unsigned cycles);
    cycles = 0;
    @(negedge clk);
    cpu_req      = 1'b1;
    cpu_in.wr    = wr;
    cpu_in.size  = size;
    cpu_in.addr  = addr;
    cpu_in.wdata = wdata;
    #(CLK_PERIOD / 4);   // sample mid cycle
    while (!cpu_data_ok) begin
        check_val("cpu_addr_ok", 32'(cpu_addr_ok), 32'd0);   // no handshake before the hit
        @(negedge clk);
        #(CLK_PERIOD / 4);
        cycles++;
    end
    check_val("cpu_addr_ok", 32'(cpu_addr_ok), 32'd1);
    rdata = data_rdata;
    @(posedge clk);   // the edge that takes the access
endtask

`endif

// File: sim/tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache import dcache_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;
    localparam int          NUM_ACCESS   = 2000;
    localparam int          NUM_TAGS     = 3;
    localparam int          NUM_READBACK = NUM_TAGS * NUM_SETS * WORDS;
    localparam int          MEM_WORDS    = 256;
    localparam int          MEM_BYTES    = 1024;
    localparam int          TIMEOUT_NS   = (NUM_ACCESS + NUM_READBACK) * 200 * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'he675d9dd;

    logic        clk;
    logic        rst;
    logic        cpu_req;
    cpu_req_t    cpu_in;
    logic [31:0] mem_rdata;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    logic        cpu_addr_ok;
    logic        cpu_data_ok;
    logic [31:0] data_rdata;
    logic        mem_req;
    mem_req_t    mem_out;

    logic [31:0] mem_word [MEM_WORDS];   // backing memory behind the cache
    int          n_checks;
    int          n_errors;
    int          wb_count;               // position inside a write-back burst
    logic [27:0] wb_line;

    `include "tb_dcache_model.svh"

    dcache_top u_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_in      (cpu_in),
        .mem_rdata   (mem_rdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .data_rdata  (data_rdata),
        .mem_req     (mem_req),
        .mem_out     (mem_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // serves one word transfer that starts at a falling edge with mem_req high
    task automatic serve_transfer();
        mem_req_t    held;
        int unsigned addr_wait;
        int unsigned data_wait;
        held      = mem_out;
        addr_wait = $urandom % 4;
        repeat (addr_wait) begin
            @(negedge clk);
            check_val("mem_req", 32'(mem_req), 32'd1);
            check_val("mem_out.addr", mem_out.addr, held.addr);
            check_val("mem_out.wdata", mem_out.wdata, held.wdata);
            check_val("mem_out.wen", 32'(mem_out.wen), 32'(held.wen));
            check_val("mem_out.last", 32'(mem_out.last), 32'(held.last));
        end
        mem_addr_ok = 1'b1;
        @(negedge clk);
        mem_addr_ok = 1'b0;
        check_val("mem_req", 32'(mem_req), 32'd0);   // nothing new until data_ok
        if (held.addr >= 32'(MEM_BYTES)) begin
            n_errors++;
            $display("error at %0t: memory access to %h lies outside the 1 KB memory",
                     $time, held.addr);
        end
        if (held.wen) begin
            if (wb_count == 0) begin
                wb_line = held.addr[31:4];
            end
            check_val("write-back line", 32'(held.addr[31:4]), 32'(wb_line));
            check_val("write-back word", 32'(held.addr[3:2]), 32'(wb_count));
            check_val("mem_out.last", 32'(held.last), 32'(wb_count == 3));
            mem_word[held.addr[9:2]] = held.wdata;
            wb_count = (wb_count + 1) % 4;
        end else begin
            if (wb_count != 0) begin
                n_errors++;
                $display("error at %0t: refill read began before the write-back burst ended",
                         $time);
            end
            check_val("mem_out.last", 32'(held.last), 32'd0);
            mem_rdata = mem_word[held.addr[9:2]];
        end
        data_wait = 1 + $urandom % 4;
        repeat (data_wait - 1) @(negedge clk);
        mem_data_ok = 1'b1;
        @(negedge clk);
        mem_data_ok = 1'b0;
    endtask

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        wb_count    = 0;
        wb_line     = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem_word[8'(a)] = fill_word(a);
        end
        @(negedge clk);
        forever begin
            if (mem_req) begin
                serve_transfer();
            end else begin
                @(negedge clk);
            end
        end
    end

    initial begin
        logic [31:0] line_addr;
        logic [31:0] prev_line;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        wr;
        logic        same_line;
        acc_size_e   size;
        int unsigned byte_off;
        int unsigned cycles;

        void'($urandom(SEED));
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_in    = '0;
        n_checks  = 0;
        n_errors  = 0;
        prev_line = '0;
        init_reference();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // nothing should move while idle after reset
        repeat (4) begin
            #(CLK_PERIOD / 4);
            check_val("mem_req", 32'(mem_req), 32'd0);
            check_val("cpu_data_ok", 32'(cpu_data_ok), 32'd0);
            @(negedge clk);
        end

        for (int n = 0; n < NUM_ACCESS; n++) begin
            if (n > 0 && ($urandom % 4) == 0) begin
                line_addr = prev_line;   // stay on the line just used
            end else begin
                line_addr = 32'(($urandom % NUM_TAGS) << (OFFSET_W + INDEX_W))
                          | 32'(($urandom % NUM_SETS) << OFFSET_W);
            end
            size = acc_size_e'(2'($urandom % 3));
            case (size)
                SZ_BYTE: byte_off = $urandom % 4;
                SZ_HALF: byte_off = ($urandom % 2) * 2;
                default: byte_off = 0;
            endcase
            addr      = line_addr | 32'(($urandom % WORDS) << 2) | 32'(byte_off);
            wr        = 1'($urandom % 2);
            wdata     = $urandom;
            same_line = (n > 0) && (line_addr == prev_line);

            cpu_access(wr, size, addr, wdata, rdata, cycles);
            if (same_line) begin
                check_val("hit wait cycles", 32'(cycles), 32'd0);
            end
            if (wr) begin
                store_reference(size, addr, wdata);
            end else begin
                check_val("data_rdata", rdata, expected_word(addr));
            end
            prev_line = line_addr;

            if (($urandom % 8) == 0) begin
                @(negedge clk);
                cpu_req = 1'b0;
            end
        end

        // read every word back including the evicted lines
        for (int a = 0; a < NUM_READBACK; a++) begin
            addr = 32'(a * 4);
            cpu_access(1'b0, SZ_WORD, addr, 32'd0, rdata, cycles);
            check_val("readback data_rdata", rdata, expected_word(addr));
        end

        @(negedge clk);
        cpu_req = 1'b0;

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out after %0d ns without finishing", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+sim
logic/dcache_pkg.sv
logic/dcache_tag_ram.sv
logic/dcache_data_ram.sv
logic/dcache_lru.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_dcache \
    -f compile.f --Mdir obj_dir -o tb_dcache_sim

./obj_dir/tb_dcache_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
